//--- Bender.yml
package:
  name: spi_ctrl

sources:
  - hdl/spi_cfg_pkg.sv
  - hdl/spi_reg_pkg.sv
  - hdl/spi_byte_fifo.sv
  - hdl/spi_frame_engine.sv
  - hdl/spi_reg_file.sv
  - hdl/spi_ctrl_top.sv
  - target: test
    files:
      - tb/spi_ctrl_checker.sv
      - tb/tb_spi_ctrl.sv

//--- files.f
hdl/spi_cfg_pkg.sv
hdl/spi_reg_pkg.sv
hdl/spi_byte_fifo.sv
hdl/spi_frame_engine.sv
hdl/spi_reg_file.sv
hdl/spi_ctrl_top.sv
tb/spi_ctrl_checker.sv
tb/tb_spi_ctrl.sv

//--- hdl/spi_byte_fifo.sv
`timescale 1ns/1ps

module spi_byte_fifo
    import spi_cfg_pkg::*;
(
    input  logic       S_SYSCLK,
    input  logic       S_RESETN,
    input  logic       push_i,
    input  logic [7:0] push_data_i,
    input  logic       pop_i,
    output logic [7:0] pop_data_o,
    output fifo_stat_t stat_o
);

    logic [7:0]            mem [FIFO_DEPTH];
    logic [FIFO_CNT_W-2:0] wr_ptr;  // wraps at FIFO_DEPTH
    logic [FIFO_CNT_W-2:0] rd_ptr;
    logic [FIFO_CNT_W-1:0] count;
    logic                  do_push;
    logic                  do_pop;

    assign stat_o.empty = (count == '0);
    assign stat_o.full  = (count == FIFO_CNT_W'(FIFO_DEPTH));
    assign stat_o.count = count;

    assign do_push    = push_i && !stat_o.full;  // push on full is lost
    assign do_pop     = pop_i && !stat_o.empty;
    assign pop_data_o = mem[rd_ptr];

    always_ff @(posedge S_SYSCLK) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data_i;
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;  // both or none
            endcase
        end
    end

    a_count_bound : assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        count <= FIFO_CNT_W'(FIFO_DEPTH));

endmodule

//--- hdl/spi_cfg_pkg.sv
package spi_cfg_pkg;

    localparam int NCS        = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_CNT_W = 4;   // holds 0..FIFO_DEPTH
    localparam int BUS_ADDR_W = 8;
    localparam int BUS_DATA_W = 32;

    typedef enum logic [2:0] {
        IDLE,
        BEF_WAIT,   // select lead time
        DATA_WAIT,  // tx fifo starved
        IN_TRANS,
        AFT_WAIT    // select trail time
    } frame_state_t;

    typedef struct packed {
        logic [BUS_ADDR_W-1:0] addr;
        logic [BUS_DATA_W-1:0] data;
    } bus_wr_req_t;

    typedef struct packed {
        logic                  empty;
        logic                  full;
        logic [FIFO_CNT_W-1:0] count;
    } fifo_stat_t;

endpackage

//--- hdl/spi_ctrl_top.sv
`timescale 1ns/1ps

module spi_ctrl_top
    import spi_cfg_pkg::*;
(
    input  logic                  S_SYSCLK,
    input  logic                  S_RESETN,
    input  logic                  awvalid_i,
    input  logic                  wvalid_i,
    input  bus_wr_req_t           wr_req_i,
    output logic                  awready_o,
    output logic                  wready_o,
    output logic                  bvalid_o,
    input  logic                  bready_i,
    input  logic [BUS_ADDR_W-1:0] araddr_i,
    input  logic                  arvalid_i,
    output logic                  arready_o,
    output logic [BUS_DATA_W-1:0] rdata_o,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output logic                  irq_o,
    output logic                  spi_sck_o,
    output logic                  spi_mosi_o,
    input  logic                  spi_miso_i,
    output logic [NCS-1:0]        spi_sel_o
);

    logic                  tx_push;
    logic [7:0]            tx_data;
    logic                  tx_pop;
    logic [7:0]            tx_head;
    fifo_stat_t            tx_stat;
    logic                  rx_push;
    logic [7:0]            rx_data;
    logic                  rx_pop;
    logic [7:0]            rx_head;
    fifo_stat_t            rx_stat;
    logic                  start;
    logic [BUS_DATA_W-1:0] mode;  // csmode word of the selected chip
    logic [BUS_DATA_W-1:0] com;
    logic                  loop;
    logic                  busy;
    logic                  done;

    spi_reg_file u_reg_file (
        .S_SYSCLK (S_SYSCLK),  .S_RESETN (S_RESETN),
        .awvalid_i(awvalid_i), .wvalid_i (wvalid_i),  .wr_req_i (wr_req_i),
        .awready_o(awready_o), .wready_o (wready_o),  .bvalid_o (bvalid_o),
        .bready_i (bready_i),  .araddr_i (araddr_i),  .arvalid_i(arvalid_i),
        .arready_o(arready_o), .rdata_o  (rdata_o),   .rvalid_o (rvalid_o),
        .rready_i (rready_i),  .irq_o    (irq_o),
        .tx_push_o(tx_push),   .tx_data_o(tx_data),   .rx_pop_o (rx_pop),
        .tx_stat_i(tx_stat),   .rx_stat_i(rx_stat),   .rx_data_i(rx_head),
        .start_o  (start),     .mode_o   (mode),      .com_o    (com),
        .loop_o   (loop),      .busy_i   (busy),      .done_i   (done)
    );

    spi_byte_fifo u_tx_fifo (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .push_i  (tx_push),  .push_data_i(tx_data),
        .pop_i   (tx_pop),   .pop_data_o (tx_head), .stat_o(tx_stat)
    );

    spi_byte_fifo u_rx_fifo (
        .S_SYSCLK(S_SYSCLK), .S_RESETN(S_RESETN),
        .push_i  (rx_push),  .push_data_i(rx_data),
        .pop_i   (rx_pop),   .pop_data_o (rx_head), .stat_o(rx_stat)
    );

    spi_frame_engine u_engine (
        .S_SYSCLK (S_SYSCLK),  .S_RESETN  (S_RESETN),
        .start_i  (start),     .mode_i    (mode),      .com_i     (com),
        .loop_i   (loop),      .tx_stat_i (tx_stat),   .tx_data_i (tx_head),
        .tx_pop_o (tx_pop),    .rx_push_o (rx_push),   .rx_data_o (rx_data),
        .busy_o   (busy),      .done_o    (done),
        .spi_sck_o(spi_sck_o), .spi_mosi_o(spi_mosi_o),
        .spi_miso_i(spi_miso_i), .spi_sel_o(spi_sel_o)
    );

endmodule

//--- hdl/spi_frame_engine.sv
`timescale 1ns/1ps

module spi_frame_engine
    import spi_cfg_pkg::*;
    import spi_reg_pkg::*;
(
    input  logic           S_SYSCLK,
    input  logic           S_RESETN,
    input  logic           start_i,
    input  csmode_t        mode_i,
    input  spcom_t         com_i,
    input  logic           loop_i,
    input  fifo_stat_t     tx_stat_i,
    input  logic [7:0]     tx_data_i,
    output logic           tx_pop_o,
    output logic           rx_push_o,
    output logic [7:0]     rx_data_o,
    output logic           busy_o,
    output logic           done_o,
    output logic           spi_sck_o,
    output logic           spi_mosi_o,
    input  logic           spi_miso_i,
    output logic [NCS-1:0] spi_sel_o
);

    frame_state_t state;
    csmode_t      mode_q;    // mode held for the whole frame
    csmode_t      act_mode;
    logic [7:0]   presc_cnt;
    logic         tick;      // half bit period
    logic         phase;     // 1 after the leading edge
    logic [2:0]   bit_cnt;
    logic [7:0]   char_cnt;
    logic [4:0]   half_cnt;
    logic [7:0]   tx_sr;
    logic [7:0]   rx_sr;
    logic         rx_push_q;
    logic         done_q;
    logic         last_bit;
    logic         load;
    logic         din;

    assign busy_o     = (state != IDLE);
    assign act_mode   = busy_o ? mode_q : mode_i;
    assign tick       = (presc_cnt == mode_q.pm);
    assign spi_mosi_o = tx_sr[7];  // msb first
    assign din        = loop_i ? spi_mosi_o : spi_miso_i;
    assign spi_sck_o  = (state == IN_TRANS) ? (act_mode.cpol ^ phase) : act_mode.cpol;
    assign last_bit   = tick && phase && (bit_cnt == 3'd7);
    assign tx_pop_o   = load;
    assign rx_push_o  = rx_push_q;
    assign rx_data_o  = rx_sr;
    assign done_o     = done_q;

    always_comb begin
        load = 1'b0;
        if (!tx_stat_i.empty) begin
            if (state == DATA_WAIT) begin
                load = 1'b1;
            end else if (state == IN_TRANS && last_bit && char_cnt != com_i.tranlen) begin
                load = 1'b1;  // next character back to back
            end
        end
    end

    always_comb begin
        spi_sel_o = '1;
        spi_sel_o[com_i.cs] = busy_o ? act_mode.pol : ~act_mode.pol;
    end

    // sampled on the leading edge
    always_ff @(posedge S_SYSCLK) begin
        if (state == IN_TRANS && tick && !phase) begin
            rx_sr <= {rx_sr[6:0], din};
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            state     <= IDLE;
            mode_q    <= CSMODE_DEF;
            presc_cnt <= '0;
            phase     <= 1'b0;
            bit_cnt   <= '0;
            char_cnt  <= '0;
            half_cnt  <= '0;
            tx_sr     <= '0;
            rx_push_q <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            rx_push_q <= 1'b0;
            done_q    <= 1'b0;
            presc_cnt <= (tick || state == IDLE) ? '0 : presc_cnt + 8'd1;
            case (state)
                IDLE: begin
                    if (start_i) begin
                        mode_q   <= mode_i;
                        half_cnt <= '0;
                        char_cnt <= '0;
                        state    <= BEF_WAIT;
                    end
                end
                BEF_WAIT: begin
                    if (half_cnt == {mode_q.csbef, 1'b0}) state <= DATA_WAIT;
                    else if (tick) half_cnt <= half_cnt + 5'd1;
                end
                DATA_WAIT: begin
                    if (load) state <= IN_TRANS;
                end
                IN_TRANS: begin
                    if (tick) begin
                        phase <= ~phase;
                        if (!phase) begin
                            rx_push_q <= (bit_cnt == 3'd7);
                        end else if (bit_cnt != 3'd7) begin
                            tx_sr   <= {tx_sr[6:0], 1'b0};  // trailing edge shift
                            bit_cnt <= bit_cnt + 3'd1;
                        end else if (char_cnt == com_i.tranlen) begin
                            half_cnt <= '0;
                            state    <= AFT_WAIT;
                        end else begin
                            char_cnt <= char_cnt + 8'd1;
                            if (!load) state <= DATA_WAIT;
                        end
                    end
                end
                AFT_WAIT: begin
                    if (half_cnt == {mode_q.csaft, 1'b0}) begin
                        state  <= IDLE;
                        done_q <= 1'b1;
                    end else if (tick) begin
                        half_cnt <= half_cnt + 5'd1;
                    end
                end
                default: state <= IDLE;
            endcase
            if (load) begin
                tx_sr     <= tx_data_i;
                presc_cnt <= '0;
                phase     <= 1'b0;
                bit_cnt   <= '0;
            end
        end
    end

    a_done_ends_busy : assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        done_o |-> !busy_o && $past(busy_o));
    a_no_pop_empty : assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        tx_pop_o |-> !tx_stat_i.empty);

endmodule

//--- hdl/spi_reg_file.sv
`timescale 1ns/1ps

module spi_reg_file
    import spi_cfg_pkg::*;
    import spi_reg_pkg::*;
(
    input  logic                  S_SYSCLK,
    input  logic                  S_RESETN,
    input  logic                  awvalid_i,
    input  logic                  wvalid_i,
    input  bus_wr_req_t           wr_req_i,
    output logic                  awready_o,
    output logic                  wready_o,
    output logic                  bvalid_o,
    input  logic                  bready_i,
    input  logic [BUS_ADDR_W-1:0] araddr_i,
    input  logic                  arvalid_i,
    output logic                  arready_o,
    output logic [BUS_DATA_W-1:0] rdata_o,
    output logic                  rvalid_o,
    input  logic                  rready_i,
    output logic                  irq_o,
    output logic                  tx_push_o,
    output logic [7:0]            tx_data_o,
    output logic                  rx_pop_o,
    input  fifo_stat_t            tx_stat_i,
    input  fifo_stat_t            rx_stat_i,
    input  logic [7:0]            rx_data_i,
    output logic                  start_o,
    output csmode_t               mode_o,
    output spcom_t                com_o,
    output logic                  loop_o,
    input  logic                  busy_i,
    input  logic                  done_i
);

    spmode_t               spmode;
    spie_t                 spie;
    logic [BUS_DATA_W-1:0] spim;
    spcom_t                spcom;
    csmode_t               csmode [NCS];
    logic                  wr_acc;
    logic                  rd_acc;
    logic [BUS_DATA_W-1:0] rd_word;

    assign wr_acc    = awvalid_i && wvalid_i && !awready_o && !bvalid_o;
    assign arready_o = !rvalid_o;
    assign rd_acc    = arvalid_i && arready_o;
    assign irq_o     = |(spie & spim);
    assign tx_push_o = awready_o && (wr_req_i.addr == ADDR_SPITF) && spmode.en;
    assign tx_data_o = wr_req_i.data[7:0];
    assign rx_pop_o  = rd_acc && (araddr_i == ADDR_SPIRF) && !rx_stat_i.empty;
    assign mode_o    = csmode[spcom.cs];
    assign com_o     = spcom;
    assign loop_o    = spmode.loop;

    // write handshake, data taken while the ready pulse is up
    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            awready_o <= 1'b0;
            wready_o  <= 1'b0;
            bvalid_o  <= 1'b0;
        end else begin
            awready_o <= wr_acc;
            wready_o  <= wr_acc;
            if (awready_o) bvalid_o <= 1'b1;
            else if (bready_i) bvalid_o <= 1'b0;
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spmode  <= SPMODE_DEF;
            spim    <= SPIM_DEF;
            spcom   <= SPCOM_DEF;
            start_o <= 1'b0;
            for (int i = 0; i < NCS; i++) begin
                csmode[i] <= CSMODE_DEF;
            end
        end else begin
            start_o <= 1'b0;
            if (awready_o) begin
                case (wr_req_i.addr)
                    ADDR_SPMODE: spmode <= wr_req_i.data;
                    ADDR_SPIM:   spim   <= wr_req_i.data;
                    ADDR_SPCOM: begin
                        if (!busy_i) begin  // ignored mid frame
                            spcom   <= wr_req_i.data;
                            start_o <= spmode.en;
                        end
                    end
                    default: ;
                endcase
                if (wr_req_i.addr[7:4] == ADDR_CSMODE0[7:4]) begin
                    csmode[wr_req_i.addr[3:2]] <= wr_req_i.data;
                end
            end
        end
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            spie <= SPIE_DEF;
        end else begin
            spie.txe   <= tx_stat_i.empty;
            spie.tnf   <= !tx_stat_i.full;
            spie.rne   <= !rx_stat_i.empty;
            spie.rxf   <= rx_stat_i.full;
            spie.rxcnt <= rx_stat_i.count;
            if (done_i) begin
                spie.don <= 1'b1;
            end else if (awready_o && wr_req_i.addr == ADDR_SPIE
                         && wr_req_i.data[SPIE_DON_BIT]) begin
                spie.don <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_word = '0;
        case (araddr_i)
            ADDR_SPMODE: rd_word = spmode;
            ADDR_SPIE:   rd_word = spie;
            ADDR_SPIM:   rd_word = spim;
            ADDR_SPCOM:  rd_word = spcom;
            ADDR_SPIRF:  rd_word = rx_stat_i.empty ? '0 : {24'h0, rx_data_i};
            default: begin
                if (araddr_i[7:4] == ADDR_CSMODE0[7:4]) rd_word = csmode[araddr_i[3:2]];
            end
        endcase
    end

    always_ff @(posedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            rvalid_o <= 1'b0;
            rdata_o  <= '0;
        end else if (rd_acc) begin
            rvalid_o <= 1'b1;
            rdata_o  <= rd_word;
        end else if (rready_i) begin
            rvalid_o <= 1'b0;
        end
    end

    a_bvalid_hold : assert property (@(posedge S_SYSCLK) disable iff (!S_RESETN)
        bvalid_o && !bready_i |=> bvalid_o);

endmodule

//--- hdl/spi_reg_pkg.sv
package spi_reg_pkg;

    // register offsets
    localparam logic [7:0] ADDR_SPMODE  = 8'h00;
    localparam logic [7:0] ADDR_SPIE    = 8'h04;
    localparam logic [7:0] ADDR_SPIM    = 8'h08;
    localparam logic [7:0] ADDR_SPCOM   = 8'h0C;
    localparam logic [7:0] ADDR_SPITF   = 8'h10;
    localparam logic [7:0] ADDR_SPIRF   = 8'h14;
    localparam logic [7:0] ADDR_CSMODE0 = 8'h20;  // one word per select up to 0x2C

    localparam int SPIE_DON_BIT = 31;  // write 1 to clear

    typedef struct packed {
        logic [29:0] rsvd;
        logic        loop;
        logic        en;
    } spmode_t;

    typedef struct packed {
        logic [1:0]  cs;
        logic [21:0] rsvd;
        logic [7:0]  tranlen;  // characters minus one
    } spcom_t;

    typedef struct packed {
        logic        cpol;
        logic        pol;     // select active level
        logic [1:0]  rsvd_hi;
        logic [3:0]  csbef;
        logic [3:0]  csaft;
        logic [11:0] rsvd_lo;
        logic [7:0]  pm;
    } csmode_t;

    typedef struct packed {
        logic        don;
        logic        txe;
        logic        tnf;
        logic        rne;
        logic        rxf;
        logic [22:0] rsvd;
        logic [3:0]  rxcnt;
    } spie_t;

    localparam spmode_t SPMODE_DEF = 32'h0000_0000;
    localparam spie_t   SPIE_DEF   = 32'h6000_0000;  // tx empty, tx not full
    localparam logic [31:0] SPIM_DEF = 32'h0000_0000;
    localparam spcom_t  SPCOM_DEF  = 32'h0000_0000;
    localparam csmode_t CSMODE_DEF = 32'h0000_0000;

endpackage

//--- tb/spi_ctrl_checker.sv
`timescale 1ns/1ps

module spi_ctrl_checker
    import spi_cfg_pkg::*;
(
    input logic           S_SYSCLK,
    input logic           S_RESETN,
    input logic           spi_sck_i,
    input logic           spi_mosi_i,
    input logic [NCS-1:0] spi_sel_i,
    input logic [1:0]     cs_i,     // select expected in the current frame
    input logic           cpol_i
);

    int             err_cnt  = 0;
    int             test_cnt = 0;
    int             err_base = 0;
    logic [7:0]     mosi_q [$];
    logic           sck_q;
    logic [NCS-1:0] sel_q;
    logic [NCS-1:0] sel_exp;
    logic [7:0]     mosi_sr;
    int             bit_cnt;

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            err_cnt++;
        end
    endtask

    function automatic void clear_mosi();
        mosi_q.delete();
    endfunction

    task automatic end_test(input string name);
        test_cnt++;
        if (err_cnt == err_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, err_cnt - err_base);
        end
        err_base = err_cnt;
    endtask

    // mosi is stable on the leading edge and shifts on the trailing one
    always @(negedge S_SYSCLK or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sck_q   = 1'b0;
            sel_q   = '1;
            bit_cnt = 0;
        end else begin
            if (spi_sel_i == '1) begin
                bit_cnt = 0;
            end else if (spi_sck_i != sck_q && spi_sck_i != cpol_i) begin
                mosi_sr = {mosi_sr[6:0], spi_mosi_i};
                bit_cnt++;
                if (bit_cnt == 8) begin
                    mosi_q.push_back(mosi_sr);
                    bit_cnt = 0;
                end
            end
            if (spi_sel_i != sel_q && spi_sel_i != '1) begin
                sel_exp = ~(NCS'(1) << cs_i);  // only one line low
                compare("spi_sel_o", spi_sel_i, sel_exp);
            end
            sck_q = spi_sck_i;
            sel_q = spi_sel_i;
        end
    end

endmodule

//--- tb/tb_spi_ctrl.sv
`timescale 1ns/1ps

module tb_spi_ctrl
    import spi_cfg_pkg::*;
    import spi_reg_pkg::*;
();

    localparam int WAIT_LIMIT = 4000;
    localparam int NUM_ENTRIES = 3;

    typedef struct {
        logic [1:0] cs;
        logic       cpol;
        logic       loop;
        logic [7:0] pm;
        int         nbytes;
        logic [7:0] tx [4];
        logic [7:0] rx [4];
    } test_entry_t;

    logic                  S_SYSCLK;
    logic                  S_RESETN;
    logic                  awvalid;
    logic                  wvalid;
    bus_wr_req_t           wr_req;
    logic                  awready;
    logic                  wready;
    logic                  bvalid;
    logic                  bready;
    logic [BUS_ADDR_W-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [BUS_DATA_W-1:0] rdata;
    logic                  rvalid;
    logic                  rready;
    logic                  irq;
    logic                  spi_sck;
    logic                  spi_mosi;
    logic                  spi_miso;
    logic [NCS-1:0]        spi_sel;
    logic [1:0]            chk_cs;
    logic                  chk_cpol;
    logic                  sck_prev;
    logic                  miso_bits [$];
    int                    miso_idx;
    int                    seed_val;
    test_entry_t           tbl [NUM_ENTRIES];

    spi_ctrl_top dut (
        .S_SYSCLK (S_SYSCLK), .S_RESETN (S_RESETN),
        .awvalid_i(awvalid),  .wvalid_i (wvalid),   .wr_req_i (wr_req),
        .awready_o(awready),  .wready_o (wready),   .bvalid_o (bvalid),
        .bready_i (bready),   .araddr_i (araddr),   .arvalid_i(arvalid),
        .arready_o(arready),  .rdata_o  (rdata),    .rvalid_o (rvalid),
        .rready_i (rready),   .irq_o    (irq),
        .spi_sck_o(spi_sck),  .spi_mosi_o(spi_mosi),
        .spi_miso_i(spi_miso), .spi_sel_o(spi_sel)
    );

    spi_ctrl_checker chk (
        .S_SYSCLK (S_SYSCLK), .S_RESETN  (S_RESETN),
        .spi_sck_i(spi_sck),  .spi_mosi_i(spi_mosi), .spi_sel_i(spi_sel),
        .cs_i     (chk_cs),   .cpol_i    (chk_cpol)
    );

    initial begin
        S_SYSCLK = 1'b0;
        forever #10 S_SYSCLK = ~S_SYSCLK;
    end

    // slave model moves to the next bit after each leading edge
    always @(negedge S_SYSCLK) begin
        if (spi_sel != '1 && spi_sck != sck_prev && spi_sck != chk_cpol) miso_idx++;
        spi_miso = (miso_idx < miso_bits.size()) ? miso_bits[miso_idx] : 1'b0;
        sck_prev = spi_sck;
    end

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s at %0t ns", what, $time);
        $display("Finished with errors");
        $finish;
    endtask

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data);
        int n;
        @(negedge S_SYSCLK);
        wr_req  = '{addr: addr, data: data};
        awvalid = 1'b1;
        wvalid  = 1'b1;
        n = 0;
        do begin
            @(negedge S_SYSCLK);
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("write address/data ready");
        end while (!(awready && wready));
        awvalid = 1'b0;
        wvalid  = 1'b0;
        n = 0;
        while (bvalid || awready) begin
            @(negedge S_SYSCLK);
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("write response");
        end
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [31:0] data);
        int n;
        @(negedge S_SYSCLK);
        araddr  = addr;
        arvalid = 1'b1;
        n = 0;
        do begin
            @(negedge S_SYSCLK);
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("read data valid");
        end while (!rvalid);
        data    = rdata;
        arvalid = 1'b0;
        @(negedge S_SYSCLK);  // rvalid drops as rready is held high
    endtask

    task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp,
                               input string name);
        logic [31:0] word;
        bus_read(addr, word);
        chk.compare(name, word, exp);
    endtask

    task automatic wait_sel_active(input logic [1:0] cs);
        int n;
        n = 0;
        while (spi_sel[cs] !== 1'b0) begin
            @(negedge S_SYSCLK);
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("select to go active");
        end
    endtask

    task automatic wait_sel_idle();
        int n;
        n = 0;
        while (spi_sel !== '1) begin
            @(negedge S_SYSCLK);
            n++;
            if (n > WAIT_LIMIT) stop_on_timeout("end of frame");
        end
    endtask

    task automatic set_entry(input int idx, input logic [1:0] cs, input logic cpol,
                             input logic loop, input logic [7:0] pm, input int n);
        tbl[idx].cs     = cs;
        tbl[idx].cpol   = cpol;
        tbl[idx].loop   = loop;
        tbl[idx].pm     = pm;
        tbl[idx].nbytes = n;
        for (int i = 0; i < 4; i++) begin
            tbl[idx].tx[i] = 8'($urandom);
            tbl[idx].rx[i] = loop ? tbl[idx].tx[i] : 8'($urandom);
        end
    endtask

    task automatic run_entry(input int idx);
        test_entry_t e;
        logic [31:0] word;
        e = tbl[idx];
        chk_cs   = e.cs;
        chk_cpol = e.cpol;
        bus_write(ADDR_CSMODE0 + 8'(4 * e.cs), {e.cpol, 3'b000, 4'd1, 4'd1, 12'd0, e.pm});
        bus_write(ADDR_SPMODE, {30'd0, e.loop, 1'b1});
        for (int i = 0; i < e.nbytes; i++) bus_write(ADDR_SPITF, {24'd0, e.tx[i]});
        miso_bits.delete();
        miso_idx = 0;
        for (int i = 0; i < e.nbytes; i++) begin
            for (int b = 7; b >= 0; b--) miso_bits.push_back(e.rx[i][b]);
        end
        chk.clear_mosi();
        bus_write(ADDR_SPCOM, {e.cs, 22'd0, 8'(e.nbytes - 1)});
        wait_sel_active(e.cs);
        chk.compare("spi_sck_o", spi_sck, e.cpol);  // rest level in the lead time
        wait_sel_idle();
        chk.compare("spi_sck_o", spi_sck, e.cpol);  // rest level after frame
        chk.compare("mosi byte count", chk.mosi_q.size(), e.nbytes);
        for (int i = 0; i < e.nbytes && i < chk.mosi_q.size(); i++) begin
            chk.compare("spi_mosi_o byte", chk.mosi_q[i], e.tx[i]);
        end
        bus_read(ADDR_SPIE, word);
        chk.compare("SPIE.DON", word[31], 1'b1);
        chk.compare("SPIE.RXCNT", word[3:0], e.nbytes);
        chk.compare("irq_o", irq, 1'b0);  // masked
        for (int i = 0; i < e.nbytes; i++) read_expect(ADDR_SPIRF, e.rx[i], "SPIRF");
        read_expect(ADDR_SPIRF, 32'h0, "SPIRF when empty");
        bus_write(ADDR_SPIM, 32'h8000_0000);
        chk.compare("irq_o", irq, 1'b1);
        bus_write(ADDR_SPIE, 32'h8000_0000);
        chk.compare("irq_o", irq, 1'b0);
        bus_read(ADDR_SPIE, word);
        chk.compare("SPIE.DON", word[31], 1'b0);
        bus_write(ADDR_SPIM, 32'h0);
        chk.end_test($sformatf("frame entry %0d", idx));
    endtask

    task automatic run_tx_full();
        logic [7:0]  bytes [9];
        logic [31:0] word;
        chk_cs   = 2'd0;
        chk_cpol = 1'b0;
        for (int i = 0; i < 9; i++) bytes[i] = 8'($urandom);
        bus_write(ADDR_CSMODE0, 32'h0);
        bus_write(ADDR_SPMODE, 32'h3);
        for (int i = 0; i < 8; i++) bus_write(ADDR_SPITF, {24'd0, bytes[i]});
        bus_read(ADDR_SPIE, word);
        chk.compare("SPIE.TNF", word[29], 1'b0);
        bus_write(ADDR_SPITF, 32'h0000_00A5);  // lost as the fifo is full
        chk.clear_mosi();
        bus_write(ADDR_SPCOM, 32'h0000_0008);
        wait_sel_active(2'd0);
        repeat (400) @(negedge S_SYSCLK);  // well past eight characters
        chk.compare("spi_sel_o", spi_sel, 4'b1110);
        chk.compare("spi_sck_o", spi_sck, 1'b0);  // idle while starved
        chk.compare("mosi byte count", chk.mosi_q.size(), 8);
        bus_write(ADDR_SPITF, {24'd0, bytes[8]});
        wait_sel_idle();
        chk.compare("mosi byte count", chk.mosi_q.size(), 9);
        for (int i = 0; i < 9 && i < chk.mosi_q.size(); i++) begin
            chk.compare("spi_mosi_o byte", chk.mosi_q[i], bytes[i]);
        end
        bus_read(ADDR_SPIE, word);
        chk.compare("SPIE.RXF", word[27], 1'b1);
        chk.compare("SPIE.RXCNT", word[3:0], 4'd8);
        for (int i = 0; i < 8; i++) read_expect(ADDR_SPIRF, bytes[i], "SPIRF");
        read_expect(ADDR_SPIRF, 32'h0, "SPIRF when empty");
        bus_write(ADDR_SPIE, 32'h8000_0000);
        chk.end_test("tx fifo full");
    endtask

    initial begin
        seed_val = $urandom(81);
        S_RESETN = 1'b0;
        awvalid  = 1'b0;
        wvalid   = 1'b0;
        wr_req   = '0;
        bready   = 1'b1;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b1;
        spi_miso = 1'b0;
        chk_cs   = 2'd0;
        chk_cpol = 1'b0;
        sck_prev = 1'b0;
        miso_idx = 0;
        set_entry(0, 2'd1, 1'b0, 1'b1, 8'd1, 3);
        set_entry(1, 2'd2, 1'b1, 1'b1, 8'd2, 2);
        set_entry(2, 2'd3, 1'b0, 1'b0, 8'd0, 3);  // miso driven by slave model
        repeat (5) @(negedge S_SYSCLK);
        S_RESETN = 1'b1;

        chk.compare("spi_sel_o", spi_sel, 4'hF);
        chk.compare("spi_sck_o", spi_sck, 1'b0);
        chk.compare("irq_o", irq, 1'b0);
        chk.compare("arready_o", arready, 1'b1);
        chk.compare("awready_o", awready, 1'b0);
        chk.compare("wready_o", wready, 1'b0);
        chk.compare("bvalid_o", bvalid, 1'b0);
        chk.compare("rvalid_o", rvalid, 1'b0);
        read_expect(ADDR_SPMODE, 32'h0, "SPMODE");
        read_expect(ADDR_SPIE, 32'h6000_0000, "SPIE");
        read_expect(ADDR_SPIM, 32'h0, "SPIM");
        read_expect(ADDR_SPCOM, 32'h0, "SPCOM");
        for (int i = 0; i < NCS; i++) read_expect(ADDR_CSMODE0 + 8'(4 * i), 32'h0, "CSMODE");
        chk.end_test("reset defaults");

        for (int i = 0; i < NUM_ENTRIES; i++) run_entry(i);
        run_tx_full();

        $display("tests %0d, errors %0d", chk.test_cnt, chk.err_cnt);
        if (chk.err_cnt == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule
